// ==== common/conv1_params.svh ====
`ifndef CONV1_PARAMS_SVH
`define CONV1_PARAMS_SVH

// image geometry, one frame
`define CONV1_IMG_W 8       // pixels per line
`define CONV1_IMG_H 6       // lines per frame

// data widths
`define CONV1_PIX_W 8       // signed pixel
`define CONV1_WGT_W 8       // signed kernel weight
`define CONV1_PSUM_W 20     // signed partial sum, 9 products plus headroom

// strobes from a window's bottom-right pixel to its result on conv_data
// line buffer reg, then one psum stage per kernel row
`define CONV1_PIPE_DEPTH 4

// taps per kernel row
`define CONV1_TAPS 3

`endif

// ==== common/conv1_data_pkg.sv ====
`default_nettype none

`include "conv1_params.svh"

package conv1_data_pkg;

  // one image sample, two's complement
  typedef logic signed [`CONV1_PIX_W-1:0] pixel_t;

  // one kernel coefficient
  typedef logic signed [`CONV1_WGT_W-1:0] weight_t;

  // three weights of one kernel row, leftmost tap in low byte
  typedef logic [`CONV1_TAPS*`CONV1_WGT_W-1:0] kernel_row_t;

  // accumulated window sum
  typedef logic signed [`CONV1_PSUM_W-1:0] psum_t;

endpackage

`default_nettype wire

// ==== common/conv1_ctrl_pkg.sv ====
`default_nettype none

`include "conv1_params.svh"

package conv1_ctrl_pkg;

  // column position within a line
  typedef logic [$clog2(`CONV1_IMG_W)-1:0] col_idx_t;

  // line position, one extra code so flush strobes sit past the last line
  typedef logic [$clog2(`CONV1_IMG_H+1)-1:0] row_idx_t;

  // line buffer waits for frame_start before taking pixels
  typedef enum logic {
    LB_IDLE,
    LB_RUN
  } lb_state_e;

endpackage

`default_nettype wire

// ==== common/pixel_col_if.sv ====
`default_nettype none

// one vertically aligned pixel column, handed on from the line buffer
interface pixel_col_if
  import conv1_data_pkg::*, conv1_ctrl_pkg::*;
();

  logic     advance; // one pixel accepted, pipeline steps
  pixel_t   px_top;  // line r-2
  pixel_t   px_mid;  // line r-1
  pixel_t   px_bot;  // line r, the pixel just received
  col_idx_t col;     // coords of px_bot
  row_idx_t row;

  modport src (
    output advance, px_top, px_mid, px_bot, col, row
  );

  modport pe (
    input advance, px_top, px_mid, px_bot
  );

  modport gate (
    input advance, col, row
  );

endinterface

`default_nettype wire

// ==== logic/line_buffer.sv ====
`default_nettype none

`include "conv1_params.svh"

module line_buffer
  import conv1_data_pkg::*, conv1_ctrl_pkg::*;
(
  input wire logic   clk,
  input wire logic   rst_n,
  input wire logic   frame_start, // one-cycle pulse ahead of pixel 0
  input wire logic   pix_valid,
  input wire pixel_t pix_data,
  pixel_col_if.src   col_out
);

  pixel_t    mem_top [`CONV1_IMG_W]; // oldest line kept
  pixel_t    mem_mid [`CONV1_IMG_W]; // previous line
  lb_state_e state;
  col_idx_t  col_cnt;                // write column, shared by both lines
  row_idx_t  row_cnt;
  logic      take;                   // pixel accepted this cycle
  logic      line_end;

  // frame_start wins over a pixel in the same cycle
  assign take     = pix_valid && (state == LB_RUN) && !frame_start;
  assign line_end = (col_cnt == col_idx_t'(`CONV1_IMG_W - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= LB_IDLE;
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (frame_start) begin
      state   <= LB_RUN;                 // armed until next reset
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (take) begin
      if (line_end) begin
        col_cnt <= '0;                   // wrap to next line
        if (row_cnt != row_idx_t'(`CONV1_IMG_H)) begin
          row_cnt <= row_cnt + 1'b1;     // stops one past last line
        end
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  // column slot rolls up: mid line moves to top, new pixel into mid
  always_ff @(posedge clk) begin
    if (take) begin
      mem_top[col_cnt] <= mem_mid[col_cnt];
      mem_mid[col_cnt] <= pix_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_out.advance <= 1'b0;
      col_out.px_top  <= '0;
      col_out.px_mid  <= '0;
      col_out.px_bot  <= '0;
      col_out.col     <= '0;
      col_out.row     <= '0;
    end else begin
      col_out.advance <= take;             // one cycle behind pix_valid
      if (take) begin
        col_out.px_top <= mem_top[col_cnt]; // old contents, before the roll
        col_out.px_mid <= mem_mid[col_cnt];
        col_out.px_bot <= pix_data;
        col_out.col    <= col_cnt;
        col_out.row    <= row_cnt;
      end
    end
  end

endmodule

`default_nettype wire

// ==== pe_array/conv1_pe.sv ====
`default_nettype none

`include "conv1_params.svh"

module conv1_pe
  import conv1_data_pkg::*;
(
  input wire logic        clk,
  input wire logic        rst_n,
  input wire logic        en,              // pipeline step
  input wire logic        wgt_load,        // take filtr_in, pass old row on
  input wire kernel_row_t filtr_in,
  input wire pixel_t      ifmap_shift_in,
  input wire psum_t       psum_in,         // from element above
  output kernel_row_t     filtr_out,       // also this element's weights
  output pixel_t          ifmap_shift_out,
  output psum_t           psum_out
);

  pixel_t  tap  [`CONV1_TAPS];  // tap[0] newest, tap[2] oldest
  weight_t wgt  [`CONV1_TAPS];  // wgt[0] leftmost
  psum_t   prod [`CONV1_TAPS];
  psum_t   psum_nxt;

  // oldest pixel is the leftmost one in the window
  always_comb begin
    for (int i = 0; i < `CONV1_TAPS; i++) begin
      wgt[i]  = filtr_out[i*`CONV1_WGT_W +: `CONV1_WGT_W];
      prod[i] = tap[`CONV1_TAPS-1-i] * wgt[i]; // signed, sized to psum
    end
  end

  assign psum_nxt        = psum_in + prod[0] + prod[1] + prod[2];
  assign ifmap_shift_out = tap[0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tap <= '{default: '0};
    end else if (en) begin
      tap[0] <= ifmap_shift_in;
      for (int i = 1; i < `CONV1_TAPS; i++) begin
        tap[i] <= tap[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      filtr_out <= '0;
    end else if (wgt_load) begin
      filtr_out <= filtr_in;
    end
  end

  // sum of taps as they stood before this step
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      psum_out <= '0;
    end else if (en) begin
      psum_out <= psum_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== pe_array/pe_column.sv ====
`default_nettype none

module pe_column
  import conv1_data_pkg::*;
(
  input wire logic        clk,
  input wire logic        rst_n,
  pixel_col_if.pe         col_in,
  input wire logic        wgt_shift,  // kernel rows arrive bottom first
  input wire kernel_row_t wgt_row,
  output psum_t           psum_out    // full window sum
);

  pixel_t      mid_d1;               // mid row, one step late
  pixel_t      bot_d1;               // bot row, two steps late
  pixel_t      bot_d2;
  psum_t       psum_01;              // element 0 to 1
  psum_t       psum_12;              // element 1 to 2
  kernel_row_t wgt_01;
  kernel_row_t wgt_12;

  // each lower row lags one step so its psum meets the one from above
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mid_d1 <= '0;
      bot_d1 <= '0;
      bot_d2 <= '0;
    end else if (col_in.advance) begin
      mid_d1 <= col_in.px_mid;
      bot_d1 <= col_in.px_bot;
      bot_d2 <= bot_d1;
    end
  end

  conv1_pe i_pe_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .en              (col_in.advance),
    .wgt_load        (wgt_shift),
    .filtr_in        (wgt_row),
    .ifmap_shift_in  (col_in.px_top),
    .psum_in         ('0),          // head of chain
    .filtr_out       (wgt_01),
    .ifmap_shift_out (),
    .psum_out        (psum_01)
  );

  conv1_pe i_pe_mid (
    .clk             (clk),
    .rst_n           (rst_n),
    .en              (col_in.advance),
    .wgt_load        (wgt_shift),
    .filtr_in        (wgt_01),
    .ifmap_shift_in  (mid_d1),
    .psum_in         (psum_01),
    .filtr_out       (wgt_12),
    .ifmap_shift_out (),
    .psum_out        (psum_12)
  );

  conv1_pe i_pe_bot (
    .clk             (clk),
    .rst_n           (rst_n),
    .en              (col_in.advance),
    .wgt_load        (wgt_shift),
    .filtr_in        (wgt_12),
    .ifmap_shift_in  (bot_d2),
    .psum_in         (psum_12),
    .filtr_out       (),            // end of weight chain
    .ifmap_shift_out (),
    .psum_out        (psum_out)
  );

endmodule

`default_nettype wire

// ==== logic/window_gate.sv ====
`default_nettype none

`include "conv1_params.svh"

module window_gate
  import conv1_ctrl_pkg::*;
(
  input wire logic clk,
  input wire logic rst_n,
  pixel_col_if.gate col_in,
  output logic     conv_valid  // one pulse per complete window
);

  localparam int DLY = `CONV1_PIPE_DEPTH - 1; // last stage feeds the valid reg

  col_idx_t col_dly [DLY];
  row_idx_t row_dly [DLY];
  logic     win_ok;

  // 3x3 window fully inside: two lines and two columns behind it
  assign win_ok = (row_dly[DLY-1] >= row_idx_t'(2)) &&
                  (row_dly[DLY-1] <  row_idx_t'(`CONV1_IMG_H)) && // drops flush strobes
                  (col_dly[DLY-1] >= col_idx_t'(2));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_dly    <= '{default: '0}; // row 0 never passes
      row_dly    <= '{default: '0};
      conv_valid <= 1'b0;
    end else begin
      conv_valid <= col_in.advance && win_ok; // lines up with psum_out
      if (col_in.advance) begin
        col_dly[0] <= col_in.col;
        row_dly[0] <= col_in.row;
        for (int i = 1; i < DLY; i++) begin
          col_dly[i] <= col_dly[i-1];
          row_dly[i] <= row_dly[i-1];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/conv1_top.sv ====
`default_nettype none

module conv1_top
  import conv1_data_pkg::*;
(
  input wire logic        clk,
  input wire logic        rst_n,
  input wire logic        frame_start,  // pulse, then raster pixels
  input wire logic        pix_valid,
  input wire pixel_t      pix_data,
  input wire logic        wgt_shift,    // only while pix_valid is low
  input wire kernel_row_t wgt_row,
  output logic            conv_valid,
  output psum_t           conv_data
);

  pixel_col_if col_bus ();  // aligned column, line buffer to column and gate

  line_buffer i_line_buffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .pix_valid   (pix_valid),
    .pix_data    (pix_data),
    .col_out     (col_bus.src)
  );

  // psum chain, result valid when the gate says so
  pe_column i_pe_column (
    .clk       (clk),
    .rst_n     (rst_n),
    .col_in    (col_bus.pe),
    .wgt_shift (wgt_shift),
    .wgt_row   (wgt_row),
    .psum_out  (conv_data)
  );

  window_gate i_window_gate (
    .clk        (clk),
    .rst_n      (rst_n),
    .col_in     (col_bus.gate),
    .conv_valid (conv_valid)
  );

endmodule

`default_nettype wire

// ==== testbench/conv1_properties.sv ====
`default_nettype none

`include "conv1_params.svh"

module conv1_properties
  import conv1_data_pkg::*;
(
  input wire logic  clk,
  input wire logic  rst_n,
  input wire logic  frame_start,
  input wire logic  advance,     // line buffer strobe
  input wire logic  conv_valid,
  input wire psum_t conv_data
);

  localparam int PSUM_MAX = 9 * 128 * 128;   // -128 times -128, nine taps
  localparam int PSUM_MIN = -9 * 128 * 127;  // 127 times -128, nine taps

  logic started;      // first frame_start seen
  int   step_cnt;     // pipeline steps since frame_start
  int   win_idx;      // raster index of the bottom-right pixel of the result
  int   err_cnt = 0;  // failed assertions, summed into the closing count

  // result on conv_data trails its bottom-right pixel by the pipe depth
  assign win_idx = step_cnt - `CONV1_PIPE_DEPTH;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started  <= 1'b0;
      step_cnt <= 0;
    end else if (frame_start) begin
      started  <= 1'b1;
      step_cnt <= 0;               // old frame's steps are flushed
    end else if (advance) begin
      step_cnt <= step_cnt + 1;
    end
  end

  reset_clears: assert property (@(posedge clk)
    !rst_n |=> !advance && !conv_valid && conv_data == '0)
    else begin
      $error("reset left advance, conv_valid or conv_data set");
      err_cnt++;
    end

  // quiet until the first frame opens
  idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !started |-> !conv_valid && conv_data == '0)
    else begin
      $error("output activity before the first frame_start");
      err_cnt++;
    end

  // window position from the step count, negative index lands in row 0
  window_inside: assert property (@(posedge clk) disable iff (!rst_n)
    conv_valid |-> win_idx / `CONV1_IMG_W >= 2 &&
                   win_idx / `CONV1_IMG_W < `CONV1_IMG_H &&
                   win_idx % `CONV1_IMG_W >= 2)
    else begin
      $error("conv_valid for a window not inside the image");
      err_cnt++;
    end

  result_range: assert property (@(posedge clk) disable iff (!rst_n)
    conv_valid |-> int'(conv_data) >= PSUM_MIN && int'(conv_data) <= PSUM_MAX)
    else begin
      $error("result outside the reachable window sum range");
      err_cnt++;
    end

endmodule

bind conv1_top conv1_properties i_conv1_properties (
  .clk         (clk),
  .rst_n       (rst_n),
  .frame_start (frame_start),
  .advance     (col_bus.advance),
  .conv_valid  (conv_valid),
  .conv_data   (conv_data)
);

`default_nettype wire

// ==== testbench/conv1_tb.sv ====
`default_nettype none

`include "conv1_params.svh"

module conv1_tb
  import conv1_data_pkg::*;
();

  localparam int W        = `CONV1_IMG_W;
  localparam int H        = `CONV1_IMG_H;
  localparam int N_FRAMES = 4;
  localparam int WINDOWS  = (W - 2) * (H - 2);  // results per frame
  localparam int TIMEOUT  = 2 * (N_FRAMES * (W * H + `CONV1_PIPE_DEPTH) + N_FRAMES * 3);

  logic        clk;
  logic        rst_n;
  logic        frame_start;
  logic        pix_valid;
  pixel_t      pix_data;
  logic        wgt_shift;
  kernel_row_t wgt_row;
  logic        conv_valid;
  psum_t       conv_data;

  pixel_t      img  [H][W];
  weight_t     kern [3][3];       // [row][col], row 0 on top
  int          exp_q [$];         // window sums in raster order
  int          exp_val;
  int          valid_cnt   = 0;   // pulses in current frame
  int          cycles      = 0;
  int          value_errs  = 0;
  int          count_errs  = 0;
  int          other_errs  = 0;
  int          assert_errs = 0;   // from the bound checker
  logic [31:0] lfsr = 32'hcaac7f45;

  conv1_top i_conv1_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .pix_valid   (pix_valid),
    .pix_data    (pix_data),
    .wgt_shift   (wgt_shift),
    .wgt_row     (wgt_row),
    .conv_valid  (conv_valid),
    .conv_data   (conv_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      v    = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic random_kernel();
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        kern[r][c] = rand_byte();
      end
    end
  endtask

  task automatic random_image();
    for (int y = 0; y < H; y++) begin
      for (int x = 0; x < W; x++) begin
        img[y][x] = rand_byte();
      end
    end
  endtask

  task automatic fill_const(input pixel_t p, input weight_t w);
    for (int y = 0; y < H; y++) begin
      for (int x = 0; x < W; x++) begin
        img[y][x] = p;
      end
    end
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        kern[r][c] = w;
      end
    end
  endtask

  // bottom kernel row goes in first, ends up in the last element
  task automatic send_kernel();
    for (int r = 2; r >= 0; r--) begin
      @(negedge clk);
      wgt_shift = 1'b1;
      wgt_row   = {kern[r][2], kern[r][1], kern[r][0]};  // leftmost tap low byte
    end
    @(negedge clk);
    wgt_shift = 1'b0;
  endtask

  task automatic push_expected();
    int acc;
    for (int y = 2; y < H; y++) begin
      for (int x = 2; x < W; x++) begin
        acc = 0;
        for (int r = 0; r < 3; r++) begin
          for (int c = 0; c < 3; c++) begin
            acc += int'(img[y-2+r][x-2+c]) * int'(kern[r][c]);
          end
        end
        exp_q.push_back(acc);
      end
    end
  endtask

  task automatic run_frame();
    push_expected();
    valid_cnt = 0;
    @(negedge clk);
    frame_start = 1'b1;
    @(negedge clk);
    frame_start = 1'b0;
    for (int y = 0; y < H; y++) begin
      for (int x = 0; x < W; x++) begin
        pix_valid = 1'b1;
        pix_data  = img[y][x];
        @(negedge clk);
      end
    end
    for (int i = 0; i < `CONV1_PIPE_DEPTH; i++) begin
      pix_data = rand_byte();  // flush, rows past the image
      @(negedge clk);
    end
    pix_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);          // timeout guards a missing result
    end
    @(negedge clk);
    assert (valid_cnt == WINDOWS) else begin
      count_errs++;
      $display("Fail %0t: %0d results in frame, expected %0d", $time, valid_cnt, WINDOWS);
    end
  endtask

  // outputs are registered, stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && conv_valid) begin
      valid_cnt++;
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("result at time %0t arrived with no window pending", $time);
      end else begin
        exp_val = exp_q.pop_front();
        assert (int'(conv_data) == exp_val) else begin
          value_errs++;
          $display("Fail %0t: conv_data %0d, expected %0d", $time, conv_data, exp_val);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, results did not complete", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    rst_n       = 1'b0;
    frame_start = 1'b0;
    pix_valid   = 1'b0;
    pix_data    = '0;
    wgt_shift   = 1'b0;
    wgt_row     = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    random_kernel();
    send_kernel();               // weights first, a stray step would move conv_data
    repeat (4) begin             // stray pixels, line buffer still idle
      @(negedge clk);
      pix_valid = 1'b1;
      pix_data  = rand_byte();
    end
    @(negedge clk);
    pix_valid = 1'b0;
    random_image();
    run_frame();
    fill_const(8'sh80, 8'sh80);  // largest positive sum
    send_kernel();
    run_frame();
    fill_const(8'sh7f, 8'sh80);  // largest negative sum
    send_kernel();
    run_frame();
    random_kernel();             // fresh weights, old lines still in memory
    random_image();
    send_kernel();
    run_frame();
    assert_errs = i_conv1_top.i_conv1_properties.err_cnt;
    $display("errors: value %0d, count %0d, other %0d, assert %0d",
             value_errs, count_errs, other_errs, assert_errs);
    if (value_errs + count_errs + other_errs + assert_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/conv1_data_pkg.sv
common/conv1_ctrl_pkg.sv
common/pixel_col_if.sv
logic/line_buffer.sv
pe_array/conv1_pe.sv
pe_array/pe_column.sv
logic/window_gate.sv
logic/conv1_top.sv
testbench/conv1_properties.sv
testbench/conv1_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the conv1 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module conv1_tb -o conv1_sim

# the log decides pass or fail
./obj_dir/conv1_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "Test passed" sim.log
